// File: compile.f
rtl/bubl_pkg.sv
rtl/main_decode.sv
rtl/work_ram_arbiter.sv
rtl/work_ram.sv
rtl/main_io_regs.sv
rtl/bus_read_mux.sv
rtl/bubl_main_board.sv
dv/tb_bubl_main.sv

// File: dv/tb_bubl_main.sv
//////////////////////////////////////////////////
// Both CPU buses driven as plain strobes, 4 clocks per access
// Work RAM data is only checked where a write landed first
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_bubl_main;
    import bubl_pkg::*;

    localparam int access_cycles   = 5;  // 4 held plus 1 idle
    localparam int max_accesses    = 220;
    localparam int watchdog_cycles = 10 + max_accesses * access_cycles + 200;

    logic        clk24 = 1'b0;
    logic        rst;
    logic [15:0] main_addr;
    logic        main_mreq_n;
    logic        main_rd_n;
    logic        main_wr_n;
    logic [7:0]  main_dout;
    logic [7:0]  main_din;
    logic        main_busy;
    logic [15:0] sub_addr;
    logic        sub_mreq_n;
    logic        sub_wr_n;
    logic [7:0]  sub_dout;
    logic [7:0]  sub_din;
    logic        sub_busy;
    logic        sub_rst_n;
    logic        main_rom_cs;
    logic [17:0] main_rom_addr;
    logic [7:0]  main_rom_data;
    logic        sub_rom_cs;
    logic [14:0] sub_rom_addr;
    logic [7:0]  sub_rom_data;
    logic        vram_cs;
    logic [7:0]  vram_dout;
    logic        pal_cs;
    logic [7:0]  pal_dout;
    logic        black_n;
    logic        flip;
    logic [7:0]  main_latch;
    logic        snd_flag;
    logic        main_stb;
    logic [7:0]  snd_latch;
    logic        snd_stb;
    logic        snd_rstn;
    logic        main_flag;

    logic [31:0] rng = 32'h95a8;
    logic [2:0]  bank_model;
    logic [7:0]  work_model [0:2**work_aw_default-1];
    logic        work_valid [0:2**work_aw_default-1];

    bubl_main_board #(.WORK_AW(work_aw_default)) DUT (.*);

    always #50 clk24 = ~clk24;

    //////////////////////////////////////////////////
    // Memory contents and reference rules

    function automatic logic [7:0] rom_byte(input logic [17:0] a);
        return a[7:0] ^ a[15:8] ^ {a[17:16], 6'h15};
    endfunction

    function automatic logic [7:0] vram_byte(input logic [15:0] a);
        return ~(a[7:0] ^ a[15:8]);
    endfunction

    function automatic logic [7:0] pal_byte(input logic [15:0] a);
        return a[7:0] + a[15:8];
    endfunction

    function automatic logic [7:0] sub_rom_byte(input logic [14:0] a);
        return a[7:0] ^ {a[14:8], 1'b1};
    endfunction

    assign main_rom_data = rom_byte(main_rom_addr);
    assign vram_dout     = vram_byte(main_addr);
    assign pal_dout      = pal_byte(main_addr);
    assign sub_rom_data  = sub_rom_byte(sub_rom_addr);

    // 16kB pages from page 2 in the 8000-BFFF window
    function automatic logic [17:0] banked_rom_addr(input logic [15:0] a, input logic [2:0] b);
        if (a >= 16'h8000 && a <= 16'hBFFF)
            return {({1'b0, b} + 4'd2), a[13:0]};
        return {3'b000, a[14:0]};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [15:0] v);
        rng = xorshift32(rng);
        v   = rng[15:0];
    endtask

    //////////////////////////////////////////////////
    // Checking

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
            else report_fail($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic expect_selects(input logic [15:0] a);
        expect_equal("main_rom_cs", 32'(main_rom_cs), 32'(a <= rom_hi));
        expect_equal("vram_cs", 32'(vram_cs), 32'(a >= vram_lo && a <= vram_hi));
        expect_equal("pal_cs", 32'(pal_cs), 32'(a >= pal_lo && a <= pal_hi));
    endtask

    a_no_main_select: assert property (@(posedge clk24) disable iff (rst)
        main_mreq_n |-> !(main_rom_cs || vram_cs || pal_cs))
        else report_fail("Main chip select active while main mreq is high");

    a_no_sub_select: assert property (@(posedge clk24) disable iff (rst)
        sub_mreq_n |-> !(sub_rom_cs || sub_busy))
        else report_fail("Sub select or busy active while sub mreq is high");

    a_stb_in_write: assert property (@(posedge clk24) disable iff (rst)
        snd_stb |-> $past(!main_mreq_n && !main_wr_n))
        else report_fail("Sound strobe high without a main write");

    //////////////////////////////////////////////////
    // Bus cycles, entered 5 ns after a rising edge

    task automatic release_buses;
        main_mreq_n = 1'b1;
        main_rd_n   = 1'b1;
        main_wr_n   = 1'b1;
        sub_mreq_n  = 1'b1;
        sub_wr_n    = 1'b1;
    endtask

    task automatic end_access;  // Called on the 4th edge
        #5;
        release_buses();
        @(posedge clk24);
        #5;
    endtask

    task automatic main_read(input logic [15:0] a);
        logic [7:0]  exp;
        logic        known;
        logic [17:0] rom_a;
        rom_a = banked_rom_addr(a, bank_model);
        known = 1'b1;
        if (a <= rom_hi)
            exp = rom_byte(rom_a);
        else if (a >= vram_lo && a <= vram_hi)
            exp = vram_byte(a);
        else if (a >= work_lo && a <= work_hi) begin
            exp   = work_model[a[work_aw_default-1:0]];
            known = work_valid[a[work_aw_default-1:0]];
        end else if (a >= pal_lo && a <= pal_hi)
            exp = pal_byte(a);
        else if (a >= snd_lo && a <= snd_hi)
            exp = a[0] ? {6'h3f, 1'b0, snd_flag} : main_latch;  // Flag cleared by this read
        else
            exp = 8'hFF;
        main_addr   = a;
        main_mreq_n = 1'b0;
        main_rd_n   = 1'b0;
        @(negedge clk24);
        expect_selects(a);
        if (a <= rom_hi)
            expect_equal("main_rom_addr", 32'(main_rom_addr), 32'(rom_a));
        repeat (2) @(negedge clk24);
        if (known)
            expect_equal("main_din", 32'(main_din), 32'(exp));
        repeat (2) @(posedge clk24);
        end_access();
    endtask

    task automatic main_write(input logic [15:0] a, input logic [7:0] d);
        logic stb_exp;
        stb_exp     = a >= snd_lo && a <= snd_hi && a[1:0] == 2'd0;
        main_addr   = a;
        main_dout   = d;
        main_mreq_n = 1'b0;
        main_wr_n   = 1'b0;
        @(negedge clk24);
        expect_selects(a);
        expect_equal("snd_stb", 32'(snd_stb), 32'd0);
        repeat (3) begin
            @(negedge clk24);
            expect_equal("snd_stb", 32'(snd_stb), 32'(stb_exp));
        end
        @(posedge clk24);
        end_access();
        if (a >= misc_lo && a <= misc_hi)
            bank_model = d[2:0] ^ 3'b100;
        if (a >= work_lo && a <= work_hi) begin
            work_model[a[work_aw_default-1:0]] = d;
            work_valid[a[work_aw_default-1:0]] = 1'b1;
        end
    endtask

    task automatic idle_decode(input logic [15:0] a);
        main_addr = a;
        main_rd_n = 1'b0;  // mreq stays high
        @(negedge clk24);
        expect_equal("main_rom_cs", 32'(main_rom_cs), 32'd0);
        expect_equal("vram_cs", 32'(vram_cs), 32'd0);
        expect_equal("pal_cs", 32'(pal_cs), 32'd0);
        @(posedge clk24);
        end_access();
    endtask

    task automatic sub_read(input logic [15:0] a);
        logic [7:0] exp;
        logic       known;
        known = 1'b1;
        if (a <= sub_rom_hi)
            exp = sub_rom_byte(a[14:0]);
        else if (a >= sub_work_lo) begin
            exp   = work_model[a[work_aw_default-1:0]];
            known = work_valid[a[work_aw_default-1:0]];
        end else
            exp = 8'hFF;
        sub_addr   = a;
        sub_wr_n   = 1'b1;
        sub_mreq_n = 1'b0;
        @(negedge clk24);
        expect_equal("sub_rom_cs", 32'(sub_rom_cs), 32'(a <= 16'h7FFF));
        expect_equal("sub_rom_addr", 32'(sub_rom_addr), 32'(a[14:0]));
        repeat (2) @(negedge clk24);
        if (known)
            expect_equal("sub_din", 32'(sub_din), 32'(exp));
        repeat (2) @(posedge clk24);
        end_access();
    endtask

    task automatic sub_write(input logic [15:0] a, input logic [7:0] d);
        sub_addr   = a;
        sub_dout   = d;
        sub_mreq_n = 1'b0;
        sub_wr_n   = 1'b0;
        repeat (4) @(posedge clk24);
        end_access();
        if (a >= sub_work_lo) begin
            work_model[a[work_aw_default-1:0]] = d;
            work_valid[a[work_aw_default-1:0]] = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    initial begin
        logic [15:0] r;
        logic [15:0] o;
        logic [15:0] a;
        logic [7:0]  d;
        rst        = 1'b1;
        main_addr  = '0;
        main_dout  = '0;
        sub_addr   = '0;
        sub_dout   = '0;
        main_latch = '0;
        snd_flag   = 1'b0;
        main_stb   = 1'b0;
        bank_model = 3'd0;
        release_buses();
        for (int i = 0; i < 2**work_aw_default; i++)
            work_valid[i] = 1'b0;
        repeat (10) @(posedge clk24);
        #5 rst = 1'b0;

        // Reset values, bank seen through the banked ROM address
        expect_equal("sub_rst_n", 32'(sub_rst_n), 32'd0);
        expect_equal("black_n", 32'(black_n), 32'd0);
        expect_equal("flip", 32'(flip), 32'd0);
        expect_equal("snd_stb", 32'(snd_stb), 32'd0);
        expect_equal("snd_rstn", 32'(snd_rstn), 32'd1);
        expect_equal("snd_latch", 32'(snd_latch), 32'd0);
        expect_equal("main_flag", 32'(main_flag), 32'd0);
        main_read(16'h8000);

        // MISC register fields
        for (int k = 0; k < 6; k++) begin
            next_rand(r);
            next_rand(o);
            d = r[7:0] | ((k == 5) ? 8'h50 : 8'h00);  // Last one releases the sub CPU
            main_write(misc_lo + {10'd0, r[13:8]}, d);
            main_read(16'h8000 + {2'b00, o[13:0]});
            main_dout = ~d;  // Other byte on the bus during the MISC read
            main_read(misc_lo + {10'd0, o[5:0]});
            expect_equal("black_n", 32'(black_n), 32'(d[6]));
            expect_equal("flip", 32'(flip), 32'(d[7]));
            expect_equal("sub_rst_n", 32'(sub_rst_n), 32'(d[4]));
        end

        // Random decode over all regions
        for (int i = 0; i < 40; i++) begin
            next_rand(r);
            next_rand(o);
            case (r[2:0])
                3'd0: a = {1'b0, o[14:0]};
                3'd1: a = 16'h8000 + {2'b00, o[13:0]};
                3'd2: a = vram_lo + {3'b000, o[12:0]};
                3'd3: a = work_lo + (o % 16'h1800);
                3'd4: a = pal_lo + {7'd0, o[8:0]};
                3'd5: a = snd_lo + {9'd0, o[6:0]};
                3'd6: a = misc_lo + {10'd0, o[5:0]};
                default: a = 16'hFA80 + (o % 16'h0580);  // Unmapped, MISC reads too
            endcase
            main_latch = r[15:8];
            main_read(a);
            idle_decode(a);
            if (i % 10 == 9)
                main_write(misc_lo, r[15:8] | 8'h50);
        end

        // Sound CPU link
        for (int k = 0; k < 4; k++) begin
            next_rand(r);
            main_write(snd_lo + {9'd0, r[6:2], 2'b00}, r[15:8]);
            expect_equal("snd_latch", 32'(snd_latch), 32'(r[15:8]));
        end
        main_write(16'hFA03, 8'h01);
        expect_equal("snd_rstn", 32'(snd_rstn), 32'd0);
        main_write(16'hFA07, 8'hFE);
        expect_equal("snd_rstn", 32'(snd_rstn), 32'd1);
        next_rand(r);
        main_latch = r[7:0];
        snd_flag   = 1'b1;
        main_read(16'hFA10);
        main_read(16'hFA11);
        snd_flag = 1'b0;
        main_read(16'hFA23);
        main_stb = 1'b1;
        @(negedge clk24);
        expect_equal("main_flag", 32'(main_flag), 32'd0);
        @(negedge clk24);
        expect_equal("main_flag", 32'(main_flag), 32'd1);
        @(posedge clk24);
        #5 main_stb = 1'b0;
        main_read(16'hFA01);
        expect_equal("main_flag", 32'(main_flag), 32'd0);

        // Work RAM shared both ways
        for (int k = 0; k < 4; k++) begin
            next_rand(r);
            next_rand(o);
            main_write(work_lo + (r % 16'h1800), o[7:0]);
            sub_read(sub_work_lo + (r % 16'h1800));
            next_rand(r);
            sub_write(sub_work_lo + (r % 16'h1800), o[15:8]);
            main_read(work_lo + (r % 16'h1800));
        end

        // Main owns first
        main_addr   = work_lo + 16'h0123;
        main_mreq_n = 1'b0;
        main_rd_n   = 1'b0;
        @(posedge clk24);
        #5;
        sub_addr   = sub_work_lo + 16'h0456;
        sub_mreq_n = 1'b0;
        @(negedge clk24);
        expect_equal("sub_busy", 32'(sub_busy), 32'd1);
        expect_equal("main_busy", 32'(main_busy), 32'd0);
        @(posedge clk24);
        end_access();

        // Sub owns first
        sub_addr   = sub_work_lo + 16'h0789;
        sub_mreq_n = 1'b0;
        @(posedge clk24);
        #5;
        main_addr   = work_lo + 16'h0abc;
        main_mreq_n = 1'b0;
        main_rd_n   = 1'b0;
        @(negedge clk24);
        expect_equal("main_busy", 32'(main_busy), 32'd1);
        expect_equal("sub_busy", 32'(sub_busy), 32'd0);
        @(posedge clk24);
        end_access();

        // Sub ROM and unmapped sub space
        for (int k = 0; k < 10; k++) begin
            next_rand(r);
            sub_read({1'b0, r[14:0]});
        end
        for (int k = 0; k < 5; k++) begin
            next_rand(r);
            sub_read(16'h8000 + (r % 16'h6000));
        end

        $display("sim passed");
        $finish;
    end

    initial begin
        #(watchdog_cycles * 100);
        report_fail("Watchdog expired before the test sequence finished");
    end

endmodule

`default_nettype wire

// File: rtl/bubl_main_board.sv
//////////////////////////////////////////////////
// CPUs sit outside. Busy outputs are wait levels
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module bubl_main_board #(
    parameter int WORK_AW = bubl_pkg::work_aw_default
) (
    input  logic                             clk24,
    input  logic                             rst,
    // Main CPU bus
    input  logic [bubl_pkg::cpu_addr_w-1:0]  main_addr,
    input  logic                             main_mreq_n,
    input  logic                             main_rd_n,
    input  logic                             main_wr_n,
    input  logic [bubl_pkg::byte_w-1:0]      main_dout,
    output logic [bubl_pkg::byte_w-1:0]      main_din,
    output logic                             main_busy,
    // Sub CPU bus
    input  logic [bubl_pkg::cpu_addr_w-1:0]  sub_addr,
    input  logic                             sub_mreq_n,
    input  logic                             sub_wr_n,
    input  logic [bubl_pkg::byte_w-1:0]      sub_dout,
    output logic [bubl_pkg::byte_w-1:0]      sub_din,
    output logic                             sub_busy,
    output logic                             sub_rst_n,
    // ROMs, video and palette
    output logic                             main_rom_cs,
    output logic [bubl_pkg::main_rom_aw-1:0] main_rom_addr,
    input  logic [bubl_pkg::byte_w-1:0]      main_rom_data,
    output logic                             sub_rom_cs,
    output logic [bubl_pkg::sub_rom_aw-1:0]  sub_rom_addr,
    input  logic [bubl_pkg::byte_w-1:0]      sub_rom_data,
    output logic                             vram_cs,
    input  logic [bubl_pkg::byte_w-1:0]      vram_dout,
    output logic                             pal_cs,
    input  logic [bubl_pkg::byte_w-1:0]      pal_dout,
    output logic                             black_n,
    output logic                             flip,
    // Sound CPU link
    input  logic [bubl_pkg::byte_w-1:0]      main_latch,
    input  logic                             snd_flag,
    input  logic                             main_stb,
    output logic [bubl_pkg::byte_w-1:0]      snd_latch,
    output logic                             snd_stb,
    output logic                             snd_rstn,
    output logic                             main_flag
);
    import bubl_pkg::*;

    main_region_e      main_region;
    logic [2:0]        bank;
    logic              main_we;
    logic              sub_we;
    logic              sub_work_sel;
    logic [byte_w-1:0] work_q0;
    logic [byte_w-1:0] work_q1;

    assign main_rom_cs  = main_region == REG_ROM;
    assign vram_cs      = main_region == REG_VRAM;
    assign pal_cs       = main_region == REG_PAL;
    assign sub_rom_addr = sub_addr[sub_rom_aw-1:0];

    main_decode u_decode (
        .main_addr     (main_addr),
        .main_mreq_n   (main_mreq_n),
        .main_wr_n     (main_wr_n),
        .bank          (bank),
        .main_region   (main_region),
        .main_rom_addr (main_rom_addr)
    );

    work_ram_arbiter #(.WORK_AW(WORK_AW)) u_arbiter (
        .clk24        (clk24),
        .rst          (rst),
        .main_region  (main_region),
        .main_wr_n    (main_wr_n),
        .sub_addr     (sub_addr),
        .sub_mreq_n   (sub_mreq_n),
        .sub_wr_n     (sub_wr_n),
        .sub_rst_n    (sub_rst_n),
        .main_we      (main_we),
        .sub_we       (sub_we),
        .sub_work_sel (sub_work_sel),
        .sub_rom_cs   (sub_rom_cs),
        .main_busy    (main_busy),
        .sub_busy     (sub_busy)
    );

    work_ram #(.WORK_AW(WORK_AW)) u_work (
        .clk24 (clk24),
        .addr0 (main_addr[WORK_AW-1:0]),
        .data0 (main_dout),
        .we0   (main_we),
        .addr1 (sub_addr[WORK_AW-1:0]),
        .data1 (sub_dout),
        .we1   (sub_we),
        .q0    (work_q0),
        .q1    (work_q1)
    );

    main_io_regs u_regs (
        .clk24       (clk24),
        .rst         (rst),
        .main_region (main_region),
        .main_addr   (main_addr[1:0]),
        .main_wr_n   (main_wr_n),
        .main_rd_n   (main_rd_n),
        .main_dout   (main_dout),
        .main_stb    (main_stb),
        .bank        (bank),
        .black_n     (black_n),
        .flip        (flip),
        .sub_rst_n   (sub_rst_n),
        .snd_latch   (snd_latch),
        .snd_stb     (snd_stb),
        .snd_rstn    (snd_rstn),
        .main_flag   (main_flag)
    );

    bus_read_mux u_rdmux (
        .clk24         (clk24),
        .main_region   (main_region),
        .main_addr0    (main_addr[0]),
        .main_rom_data (main_rom_data),
        .vram_dout     (vram_dout),
        .pal_dout      (pal_dout),
        .work_q0       (work_q0),
        .main_latch    (main_latch),
        .main_flag     (main_flag),
        .snd_flag      (snd_flag),
        .sub_rom_cs    (sub_rom_cs),
        .sub_work_sel  (sub_work_sel),
        .sub_rom_data  (sub_rom_data),
        .work_q1       (work_q1),
        .main_din      (main_din),
        .sub_din       (sub_din)
    );

endmodule

`default_nettype wire

// File: rtl/bubl_pkg.sv
//////////////////////////////////////////////////
// Bubble Bobble memory map only. Bounds are inclusive
//////////////////////////////////////////////////
`default_nettype none

package bubl_pkg;

    localparam int cpu_addr_w      = 16;
    localparam int byte_w          = 8;
    localparam int main_rom_aw     = 18;
    localparam int sub_rom_aw      = 15;
    localparam int work_aw_default = 13;  // 8kB shared work RAM

    localparam logic [3:0]        bank_base = 4'd2;    // First banked ROM page
    localparam logic [2:0]        bank_flip = 3'b100;  // Top bank bit is inverted
    localparam logic [byte_w-1:0] open_bus  = 8'hFF;

    // Main CPU map
    localparam logic [cpu_addr_w-1:0] rom_hi  = 16'hBFFF;
    localparam logic [cpu_addr_w-1:0] bank_lo = 16'h8000;  // Banked window up to rom_hi
    localparam logic [cpu_addr_w-1:0] vram_lo = 16'hC000;
    localparam logic [cpu_addr_w-1:0] vram_hi = 16'hDFFF;
    localparam logic [cpu_addr_w-1:0] work_lo = 16'hE000;
    localparam logic [cpu_addr_w-1:0] work_hi = 16'hF7FF;
    localparam logic [cpu_addr_w-1:0] pal_lo  = 16'hF800;
    localparam logic [cpu_addr_w-1:0] pal_hi  = 16'hF9FF;
    localparam logic [cpu_addr_w-1:0] snd_lo  = 16'hFA00;
    localparam logic [cpu_addr_w-1:0] snd_hi  = 16'hFA7F;
    localparam logic [cpu_addr_w-1:0] misc_lo = 16'hFB40;  // Write only
    localparam logic [cpu_addr_w-1:0] misc_hi = 16'hFB7F;

    // Sub CPU map
    localparam logic [cpu_addr_w-1:0] sub_rom_hi  = 16'h7FFF;
    localparam logic [cpu_addr_w-1:0] sub_work_lo = 16'hE000;  // Up to FFFF

    typedef enum logic [2:0] {
        REG_NONE,
        REG_ROM,
        REG_VRAM,
        REG_WORK,
        REG_PAL,
        REG_SOUND,
        REG_MISC
    } main_region_e;

endpackage

`default_nettype wire

// File: rtl/bus_read_mux.sv
//////////////////////////////////////////////////
// Read data lands one clock after the source byte
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module bus_read_mux (
    input  logic                        clk24,
    input  bubl_pkg::main_region_e      main_region,
    input  logic                        main_addr0,
    input  logic [bubl_pkg::byte_w-1:0] main_rom_data,
    input  logic [bubl_pkg::byte_w-1:0] vram_dout,
    input  logic [bubl_pkg::byte_w-1:0] pal_dout,
    input  logic [bubl_pkg::byte_w-1:0] work_q0,
    input  logic [bubl_pkg::byte_w-1:0] main_latch,
    input  logic                        main_flag,
    input  logic                        snd_flag,
    input  logic                        sub_rom_cs,
    input  logic                        sub_work_sel,
    input  logic [bubl_pkg::byte_w-1:0] sub_rom_data,
    input  logic [bubl_pkg::byte_w-1:0] work_q1,
    output logic [bubl_pkg::byte_w-1:0] main_din,
    output logic [bubl_pkg::byte_w-1:0] sub_din
);
    import bubl_pkg::*;

    logic [byte_w-1:0] snd_status;

    assign snd_status = {6'h3f, main_flag, snd_flag};

    always_ff @(posedge clk24) begin
        case (main_region)
            REG_ROM:   main_din <= main_rom_data;
            REG_VRAM:  main_din <= vram_dout;
            REG_PAL:   main_din <= pal_dout;
            REG_WORK:  main_din <= work_q0;
            REG_SOUND: main_din <= main_addr0 ? snd_status : main_latch;
            default:   main_din <= open_bus;  // MISC reads included
        endcase
    end

    always_ff @(posedge clk24) begin
        if (sub_rom_cs)
            sub_din <= sub_rom_data;
        else if (sub_work_sel)
            sub_din <= work_q1;
        else
            sub_din <= open_bus;
    end

endmodule

`default_nettype wire

// File: rtl/main_decode.sv
//////////////////////////////////////////////////
// Purely combinational. MISC reads decode as NONE
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module main_decode (
    input  logic [bubl_pkg::cpu_addr_w-1:0]  main_addr,
    input  logic                             main_mreq_n,
    input  logic                             main_wr_n,
    input  logic [2:0]                       bank,
    output bubl_pkg::main_region_e           main_region,
    output logic [bubl_pkg::main_rom_aw-1:0] main_rom_addr
);
    import bubl_pkg::*;

    main_region_e region_raw;
    logic         in_window;

    always_comb begin
        if (main_addr <= rom_hi)
            region_raw = REG_ROM;
        else if (main_addr >= vram_lo && main_addr <= vram_hi)
            region_raw = REG_VRAM;
        else if (main_addr >= work_lo && main_addr <= work_hi)
            region_raw = REG_WORK;
        else if (main_addr >= pal_lo && main_addr <= pal_hi)
            region_raw = REG_PAL;
        else if (main_addr >= snd_lo && main_addr <= snd_hi)
            region_raw = REG_SOUND;
        else if (main_addr >= misc_lo && main_addr <= misc_hi && !main_wr_n)
            region_raw = REG_MISC;
        else
            region_raw = REG_NONE;  // Old mcram, tres and nmi areas land here

        main_region = main_mreq_n ? REG_NONE : region_raw;

        // Selection must never leak out of a memory cycle
        assert (!(main_mreq_n && main_region != REG_NONE));
    end

    //////////////////////////////////////////////////
    // ROM address: 32kB fixed, 16kB pages above 8000

    assign in_window = main_addr >= bank_lo && main_addr <= rom_hi;

    always_comb begin
        if (in_window)
            main_rom_addr = {{1'b0, bank} + bank_base, main_addr[13:0]};
        else
            main_rom_addr = {3'd0, main_addr[14:0]};
    end

endmodule

`default_nettype wire

// File: rtl/main_io_regs.sv
//////////////////////////////////////////////////
// Control bits and sound CPU link. No clock enables
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module main_io_regs (
    input  logic                        clk24,
    input  logic                        rst,
    input  bubl_pkg::main_region_e      main_region,
    input  logic [1:0]                  main_addr,
    input  logic                        main_wr_n,
    input  logic                        main_rd_n,
    input  logic [bubl_pkg::byte_w-1:0] main_dout,
    input  logic                        main_stb,
    output logic [2:0]                  bank,
    output logic                        black_n,
    output logic                        flip,
    output logic                        sub_rst_n,
    output logic [bubl_pkg::byte_w-1:0] snd_latch,
    output logic                        snd_stb,
    output logic                        snd_rstn,
    output logic                        main_flag
);
    import bubl_pkg::*;

    logic snd_wr;
    logic snd_rd;
    logic last_stb;

    assign snd_wr = main_region == REG_SOUND && !main_wr_n;
    assign snd_rd = main_region == REG_SOUND && !main_rd_n;

    //////////////////////////////////////////////////
    // Misc control register, FB40-FB7F

    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            bank      <= 3'd0;
            black_n   <= 1'b0;  // Screen blanked
            flip      <= 1'b0;
            sub_rst_n <= 1'b0;  // Sub CPU held in reset
        end else if (main_region == REG_MISC) begin
            bank      <= main_dout[2:0] ^ bank_flip;
            black_n   <= main_dout[6];
            sub_rst_n <= main_dout[4];
            flip      <= main_dout[7];
        end
    end

    // Sound CPU latch and reset
    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            snd_latch <= '0;
            snd_rstn  <= 1'b1;  // Sound CPU runs from power up
            snd_stb   <= 1'b0;
        end else begin
            snd_stb <= snd_wr && main_addr == 2'd0;  // Lasts the whole write
            if (snd_wr) begin
                case (main_addr)
                    2'd0: snd_latch <= main_dout;
                    2'd3: snd_rstn  <= ~main_dout[0];
                    default: ;
                endcase
            end
        end
    end

    // Flag raised by the sound CPU strobe, cleared by reading it
    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            last_stb  <= 1'b0;
            main_flag <= 1'b0;
        end else begin
            last_stb <= main_stb;
            if (snd_rd)
                main_flag <= 1'b0;
            else if (main_stb && !last_stb)
                main_flag <= 1'b1;
        end
    end

    a_stb_after_write: assert property (@(posedge clk24) disable iff (rst)
        $rose(snd_stb) |-> $past(snd_wr && main_addr == 2'd0));

endmodule

`default_nettype wire

// File: rtl/work_ram.sv
//////////////////////////////////////////////////
// Write first per port. Port 1 wins on collision
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module work_ram #(
    parameter int WORK_AW = bubl_pkg::work_aw_default
) (
    input  logic                        clk24,
    input  logic [WORK_AW-1:0]          addr0,
    input  logic [bubl_pkg::byte_w-1:0] data0,
    input  logic                        we0,
    input  logic [WORK_AW-1:0]          addr1,
    input  logic [bubl_pkg::byte_w-1:0] data1,
    input  logic                        we1,
    output logic [bubl_pkg::byte_w-1:0] q0,
    output logic [bubl_pkg::byte_w-1:0] q1
);
    import bubl_pkg::*;

    logic [byte_w-1:0] mem [0:2**WORK_AW-1];

    always_ff @(posedge clk24) begin
        if (we0)
            mem[addr0] <= data0;
        if (we1)
            mem[addr1] <= data1;
        q0 <= we0 ? data0 : mem[addr0];
        q1 <= we1 ? data1 : mem[addr1];
    end

endmodule

`default_nettype wire

// File: rtl/work_ram_arbiter.sv
//////////////////////////////////////////////////
// Busy levels only; the CPUs must hold their bus
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module work_ram_arbiter #(
    parameter int WORK_AW = bubl_pkg::work_aw_default
) (
    input  logic                            clk24,
    input  logic                            rst,
    input  bubl_pkg::main_region_e          main_region,
    input  logic                            main_wr_n,
    input  logic [bubl_pkg::cpu_addr_w-1:0] sub_addr,
    input  logic                            sub_mreq_n,
    input  logic                            sub_wr_n,
    input  logic                            sub_rst_n,
    output logic                            main_we,
    output logic                            sub_we,
    output logic                            sub_work_sel,
    output logic                            sub_rom_cs,
    output logic                            main_busy,
    output logic                            sub_busy
);
    import bubl_pkg::*;

    logic main_sel;
    logic main_owns;
    logic sub_owns;

    // Sub CPU decode
    assign sub_rom_cs   = !sub_mreq_n && sub_addr <= sub_rom_hi;
    assign sub_work_sel = !sub_mreq_n &&
        sub_addr[cpu_addr_w-1:WORK_AW] == sub_work_lo[cpu_addr_w-1:WORK_AW];

    assign main_sel = main_region == REG_WORK;

    //////////////////////////////////////////////////
    // Ownership flags

    always_ff @(posedge clk24 or posedge rst) begin
        if (rst)
            main_owns <= 1'b0;
        else
            main_owns <= main_sel;  // Main always wins on the next clock
    end

    always_ff @(posedge clk24 or posedge rst) begin
        if (rst) begin
            sub_owns <= 1'b0;
        end else if (!sub_rst_n || !sub_work_sel) begin
            sub_owns <= 1'b0;
        end else if (!main_sel) begin
            sub_owns <= 1'b1;  // Only grabbed while main is away
        end
    end

    assign main_we   = main_owns && !main_wr_n;
    assign sub_we    = sub_work_sel && !sub_wr_n;
    assign main_busy = sub_owns && main_sel;
    assign sub_busy  = main_owns && sub_work_sel;

    // Main writes only land in a cycle that followed a WORK select
    a_main_we_owned: assert property (@(posedge clk24) disable iff (rst)
        main_we |-> main_owns && $past(main_region == REG_WORK));

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_bubl_main -f compile.f -o tb_bubl_main

status=0
./obj_dir/tb_bubl_main > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit "$status"
